// ==== source/peri_fabric_cfg.svh ====
/*
 * Shared sizes, register offsets and reset pin functions of the peripheral fabric.
 * Included by the RTL and the testbench wherever a dimension or offset is needed.
 */
`ifndef PERI_FABRIC_CFG_SVH
`define PERI_FABRIC_CFG_SVH

// Core bus
`define PERI_ADDR_W         11
`define PERI_DATA_W         32
`define PERI_PINS           8

// Full slots are 64 bytes each, simple slots 16 bytes each
`define PERI_USER_SLOTS     8
`define PERI_EXT_FIRST      2
`define PERI_EXT_SLOTS      6
`define PERI_SIMPLE_SLOTS   8
`define PERI_FULL_OFS_W     6
`define PERI_SIMPLE_OFS_W   4
`define PERI_SLOT_GPIO      1

// GPIO register map
`define PERI_GPIO_OUT_OFS   6'h00
`define PERI_GPIO_IN_OFS    6'h04
`define PERI_GPIO_FUNC_OFS  6'h20

// Pins below PERI_FUNC_LOW_PINS come up on full slot 2, the rest on GPIO
`define PERI_FUNC_LOW_PINS   2
`define PERI_FUNC_RESET_LOW  4'h2
`define PERI_FUNC_RESET_HIGH 4'h1

`endif

// ==== source/peri_fabric_pkg.sv ====
/*
 * Types shared by the fabric modules: the bus access-size code and the
 * per-pin function select.
 */
`default_nettype none

`include "peri_fabric_cfg.svh"

package peri_fabric_pkg;

    // Active-low size code, 11 means no access
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    localparam int SLOT_IDX_W = $clog2(`PERI_USER_SLOTS);

    // Output pin source: a simple slot or a full slot
    typedef struct packed {
        logic                  simple;
        logic [SLOT_IDX_W-1:0] slot;
    } pin_func_t;

endpackage

`default_nettype wire

// ==== source/peri_bus_decoder.sv ====
/*
 * Address decoder of the peripheral fabric.
 * Selects one read source per address, gates the per-slot size codes and
 * write strobes, and returns the selected read data and ready level.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module peri_bus_decoder (
    input  wire logic [`PERI_ADDR_W-1:0]                          i_addr,
    input  peri_fabric_pkg::access_t                              i_write_n,
    input  peri_fabric_pkg::access_t                              i_read_n,
    input  wire logic                                             i_hold,
    input  wire logic [`PERI_DATA_W-1:0]                          i_gpio_rdata,
    input  wire logic [`PERI_EXT_SLOTS-1:0][`PERI_DATA_W-1:0]     i_ext_rdata,
    input  wire logic [`PERI_EXT_SLOTS-1:0]                       i_ext_ready,
    input  wire logic [`PERI_SIMPLE_SLOTS-1:0][7:0]               i_simple_rdata,
    output logic                                                  o_gpio_sel,
    output peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]        o_ext_write_n,
    output peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]        o_ext_read_n,
    output logic [`PERI_SIMPLE_SLOTS-1:0]                         o_simple_write,
    output logic [`PERI_DATA_W-1:0]                               o_src_rdata,
    output logic                                                  o_src_ready
);

    localparam int FULL_IDX_W   = $clog2(`PERI_USER_SLOTS);
    localparam int SIMPLE_IDX_W = $clog2(`PERI_SIMPLE_SLOTS);
    localparam int FULL_TOP     = `PERI_FULL_OFS_W + FULL_IDX_W;
    localparam int SIMPLE_TOP   = `PERI_SIMPLE_OFS_W + SIMPLE_IDX_W;
    localparam logic [`PERI_ADDR_W-1:0] SIMPLE_BASE = 'h400;

    logic [FULL_IDX_W-1:0]    full_idx;
    logic [SIMPLE_IDX_W-1:0]  simple_idx;
    logic [FULL_IDX_W-1:0]    ext_idx;
    logic                     full_hit;
    logic                     simple_hit;
    logic                     ext_hit;
    peri_fabric_pkg::access_t read_n;

    assign full_idx   = i_addr[`PERI_FULL_OFS_W +: FULL_IDX_W];
    assign simple_idx = i_addr[`PERI_SIMPLE_OFS_W +: SIMPLE_IDX_W];
    assign ext_idx    = full_idx - FULL_IDX_W'(`PERI_EXT_FIRST);

    // 0x000-0x1FF full slots, 0x400-0x47F simple slots, all else unmapped
    assign full_hit   = (i_addr[`PERI_ADDR_W-1:FULL_TOP] == '0);
    assign simple_hit = (i_addr[`PERI_ADDR_W-1:SIMPLE_TOP]
                         == SIMPLE_BASE[`PERI_ADDR_W-1:SIMPLE_TOP]);
    assign ext_hit    = full_hit
                        && (full_idx >= FULL_IDX_W'(`PERI_EXT_FIRST))
                        && (ext_idx < FULL_IDX_W'(`PERI_EXT_SLOTS));

    // No new read reaches a slot while the buffer still holds its result
    assign read_n = i_hold ? peri_fabric_pkg::ACC_NONE : i_read_n;

    always_comb begin
        o_gpio_sel     = 1'b0;
        o_simple_write = '0;
        for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
            o_ext_write_n[k] = peri_fabric_pkg::ACC_NONE;
            o_ext_read_n[k]  = peri_fabric_pkg::ACC_NONE;
        end

        // Reserved and unmapped space reads zero and is ready at once
        o_src_rdata = '0;
        o_src_ready = 1'b1;

        if (ext_hit) begin
            o_ext_write_n[ext_idx] = i_write_n;
            o_ext_read_n[ext_idx]  = read_n;
            o_src_rdata            = i_ext_rdata[ext_idx];
            o_src_ready            = i_ext_ready[ext_idx];
        end else if (full_hit && (full_idx == FULL_IDX_W'(`PERI_SLOT_GPIO))) begin
            o_gpio_sel  = 1'b1;
            o_src_rdata = i_gpio_rdata;
        end else if (simple_hit) begin
            o_simple_write[simple_idx] = (i_write_n != peri_fabric_pkg::ACC_NONE);
            o_src_rdata = {{(`PERI_DATA_W-8){1'b0}}, i_simple_rdata[simple_idx]};
        end
    end

endmodule

`default_nettype wire

// ==== source/peri_gpio_regs.sv ====
/*
 * GPIO block in full slot 1: output byte, input readback and
 * one function-select register per output pin.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module peri_gpio_regs (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire logic                                     i_sel,
    input  wire logic [`PERI_FULL_OFS_W-1:0]              i_offset,
    input  wire logic [`PERI_DATA_W-1:0]                  i_wdata,
    input  peri_fabric_pkg::access_t                      i_write_n,
    input  wire logic [`PERI_PINS-1:0]                    i_ui_in,
    output logic [`PERI_DATA_W-1:0]                       o_rdata,
    output logic [`PERI_PINS-1:0]                         o_gpio_out,
    output peri_fabric_pkg::pin_func_t [`PERI_PINS-1:0]   o_pin_func
);

    localparam int OFS_W      = `PERI_FULL_OFS_W;
    localparam int FUNC_IDX_W = $clog2(`PERI_PINS);
    localparam int FUNC_W     = $bits(peri_fabric_pkg::pin_func_t);

    logic                  wr_en;
    logic [OFS_W-1:0]      func_rel;
    logic [FUNC_IDX_W-1:0] func_idx;
    logic                  func_hit;

    assign wr_en = i_sel && (i_write_n != peri_fabric_pkg::ACC_NONE);

    // Function registers sit 4 bytes apart from the function base
    assign func_rel = i_offset - OFS_W'(`PERI_GPIO_FUNC_OFS);
    assign func_idx = func_rel[2 +: FUNC_IDX_W];
    assign func_hit = (i_offset >= OFS_W'(`PERI_GPIO_FUNC_OFS))
                      && (func_rel[OFS_W-1:2+FUNC_IDX_W] == '0)
                      && (func_rel[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (wr_en && (i_offset == OFS_W'(`PERI_GPIO_OUT_OFS))) begin
            o_gpio_out <= i_wdata[`PERI_PINS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `PERI_PINS; p++) begin
                o_pin_func[p] <= (p < `PERI_FUNC_LOW_PINS)
                                 ? peri_fabric_pkg::pin_func_t'(`PERI_FUNC_RESET_LOW)
                                 : peri_fabric_pkg::pin_func_t'(`PERI_FUNC_RESET_HIGH);
            end
        end else if (wr_en && func_hit) begin
            o_pin_func[func_idx] <= peri_fabric_pkg::pin_func_t'(i_wdata[FUNC_W-1:0]);
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_offset == OFS_W'(`PERI_GPIO_OUT_OFS)) begin
            o_rdata[`PERI_PINS-1:0] = o_gpio_out;
        end else if (i_offset == OFS_W'(`PERI_GPIO_IN_OFS)) begin
            o_rdata[`PERI_PINS-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rdata[FUNC_W-1:0] = o_pin_func[func_idx];
        end
    end

endmodule

`default_nettype wire

// ==== source/peri_read_buffer.sv ====
/*
 * Read return register between the decoder and the core.
 * Captures the selected source on a ready read and keeps it until the core
 * pulses read-complete; writes are acknowledged in the same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module peri_read_buffer (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  peri_fabric_pkg::access_t      i_read_n,
    input  peri_fabric_pkg::access_t      i_write_n,
    input  wire logic [`PERI_DATA_W-1:0]  i_src_rdata,
    input  wire logic                     i_src_ready,
    input  wire logic                     i_read_complete,
    output logic [`PERI_DATA_W-1:0]       o_rdata,
    output logic                          o_data_ready,
    output logic                          o_hold
);

    logic read_req;
    logic capture;
    logic read_ready_q;

    assign read_req = (i_read_n != peri_fabric_pkg::ACC_NONE);
    assign capture  = !o_hold && read_req && i_src_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_hold       <= 1'b0;
            read_ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                o_hold <= 1'b0;
            end
            // A fresh capture wins over a completion in the same cycle
            if (capture) begin
                o_hold <= 1'b1;
            end
            read_ready_q <= read_req && i_src_ready;
        end
    end

    // Data stays frozen while held, so the slot need not keep driving it
    always_ff @(posedge clk) begin
        if (capture) begin
            o_rdata <= i_src_rdata;
        end
    end

    assign o_data_ready = read_ready_q || (i_write_n != peri_fabric_pkg::ACC_NONE);

endmodule

`default_nettype wire

// ==== source/peri_pin_mux.sv ====
/*
 * Output pin multiplexer.
 * Each output pin takes its own bit from the slot named by its function
 * register; full slot 0 drives zero and full slot 1 is the GPIO byte.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module peri_pin_mux (
    input  peri_fabric_pkg::pin_func_t [`PERI_PINS-1:0]            i_pin_func,
    input  wire logic [`PERI_PINS-1:0]                             i_gpio_out,
    input  wire logic [`PERI_EXT_SLOTS-1:0][`PERI_PINS-1:0]        i_ext_pins,
    input  wire logic [`PERI_SIMPLE_SLOTS-1:0][`PERI_PINS-1:0]     i_simple_pins,
    output logic [`PERI_PINS-1:0]                                  o_uo_out
);

    // Pin bytes of every full slot, indexed by full slot number
    logic [`PERI_USER_SLOTS-1:0][`PERI_PINS-1:0] full_pins;

    always_comb begin
        full_pins = '0;
        full_pins[`PERI_SLOT_GPIO] = i_gpio_out;
        for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
            full_pins[`PERI_EXT_FIRST + k] = i_ext_pins[k];
        end
    end

    for (genvar p = 0; p < `PERI_PINS; p++) begin : g_pin
        peri_fabric_pkg::pin_func_t func;

        assign func = i_pin_func[p];

        always_comb begin
            if (func.simple) begin
                o_uo_out[p] = i_simple_pins[func.slot][p];
            end else begin
                o_uo_out[p] = full_pins[func.slot][p];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/peri_fabric_top.sv ====
/*
 * Peripheral bus fabric top level.
 * Connects the core bus to the address decoder, the GPIO block, the read
 * buffer and the pin multiplexer; external and simple slots hang off its ports.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module peri_fabric_top (
    input  wire logic                                           clk,
    input  wire logic                                           rst_n,

    // Core bus
    input  wire logic [`PERI_ADDR_W-1:0]                        i_addr,
    input  wire logic [`PERI_DATA_W-1:0]                        i_wdata,
    input  peri_fabric_pkg::access_t                            i_write_n,
    input  peri_fabric_pkg::access_t                            i_read_n,
    input  wire logic                                           i_read_complete,
    output logic [`PERI_DATA_W-1:0]                             o_rdata,
    output logic                                                o_data_ready,

    // External full slots, index k is full slot k+2
    output logic [`PERI_FULL_OFS_W-1:0]                         o_ext_addr,
    output logic [`PERI_DATA_W-1:0]                             o_ext_wdata,
    output peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]      o_ext_write_n,
    output peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]      o_ext_read_n,
    input  wire logic [`PERI_EXT_SLOTS-1:0][`PERI_DATA_W-1:0]   i_ext_rdata,
    input  wire logic [`PERI_EXT_SLOTS-1:0]                     i_ext_ready,
    input  wire logic [`PERI_EXT_SLOTS-1:0][`PERI_PINS-1:0]     i_ext_pins,

    // Simple byte slots
    output logic [`PERI_SIMPLE_OFS_W-1:0]                       o_simple_addr,
    output logic [7:0]                                          o_simple_wdata,
    output logic [`PERI_SIMPLE_SLOTS-1:0]                       o_simple_write,
    input  wire logic [`PERI_SIMPLE_SLOTS-1:0][7:0]             i_simple_rdata,
    input  wire logic [`PERI_SIMPLE_SLOTS-1:0][`PERI_PINS-1:0]  i_simple_pins,

    // Pins
    input  wire logic [`PERI_PINS-1:0]                          i_ui_in,
    output logic [`PERI_PINS-1:0]                               o_uo_out
);

    logic                                       gpio_sel;
    logic [`PERI_DATA_W-1:0]                    gpio_rdata;
    logic [`PERI_PINS-1:0]                      gpio_out;
    peri_fabric_pkg::pin_func_t [`PERI_PINS-1:0] pin_func;
    logic [`PERI_DATA_W-1:0]                    src_rdata;
    logic                                       src_ready;
    logic                                       hold;

    // Address and write data are shared by every slot
    assign o_ext_addr     = i_addr[`PERI_FULL_OFS_W-1:0];
    assign o_ext_wdata    = i_wdata;
    assign o_simple_addr  = i_addr[`PERI_SIMPLE_OFS_W-1:0];
    assign o_simple_wdata = i_wdata[7:0];

    peri_bus_decoder i_decoder (
        .i_addr         (i_addr),
        .i_write_n      (i_write_n),
        .i_read_n       (i_read_n),
        .i_hold         (hold),
        .i_gpio_rdata   (gpio_rdata),
        .i_ext_rdata    (i_ext_rdata),
        .i_ext_ready    (i_ext_ready),
        .i_simple_rdata (i_simple_rdata),
        .o_gpio_sel     (gpio_sel),
        .o_ext_write_n  (o_ext_write_n),
        .o_ext_read_n   (o_ext_read_n),
        .o_simple_write (o_simple_write),
        .o_src_rdata    (src_rdata),
        .o_src_ready    (src_ready)
    );

    peri_gpio_regs i_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (gpio_sel),
        .i_offset   (i_addr[`PERI_FULL_OFS_W-1:0]),
        .i_wdata    (i_wdata),
        .i_write_n  (i_write_n),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_pin_func (pin_func)
    );

    peri_read_buffer i_read_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_src_rdata     (src_rdata),
        .i_src_ready     (src_ready),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready),
        .o_hold          (hold)
    );

    peri_pin_mux i_pin_mux (
        .i_pin_func    (pin_func),
        .i_gpio_out    (gpio_out),
        .i_ext_pins    (i_ext_pins),
        .i_simple_pins (i_simple_pins),
        .o_uo_out      (o_uo_out)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_peri_fabric_tasks.svh ====
/*
 * Bus tasks, the value check and the directed tests of the fabric testbench.
 * Included inside the testbench top module.
 */
`ifndef TB_PERI_FABRIC_TASKS_SVH
`define TB_PERI_FABRIC_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        abort_run($sformatf("** Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                            $time, name, actual, expected));
    end
endtask

function automatic logic [`PERI_ADDR_W-1:0] gpio_addr(input int ofs);
    return 11'(GPIO_BASE + ofs);
endfunction

// One-cycle write, acknowledged in the same cycle
// Strobe and ext_slot name the slot that must see the write, -1 for no external slot
task automatic bus_write(input logic [`PERI_ADDR_W-1:0] addr, input logic [31:0] data,
                         input logic [7:0] strobe, input int ext_slot);
    logic [2*`PERI_EXT_SLOTS-1:0] write_codes;
    for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
        write_codes[2*k +: 2] = (k == ext_slot) ? peri_fabric_pkg::ACC_WORD
                                                : peri_fabric_pkg::ACC_NONE;
    end
    @(posedge clk);
    i_addr    <= addr;
    i_wdata   <= data;
    i_write_n <= peri_fabric_pkg::ACC_WORD;
    @(negedge clk);
    check_value("o_data_ready", 32'(o_data_ready), 32'd1);
    check_value("o_simple_write", 32'(o_simple_write), 32'(strobe));
    check_value("o_simple_wdata", 32'(o_simple_wdata), 32'(data[7:0]));
    check_value("o_simple_addr", 32'(o_simple_addr), 32'(addr[3:0]));
    check_value("o_ext_write_n", 32'(o_ext_write_n), 32'(write_codes));
    check_value("o_ext_wdata", o_ext_wdata, data);
    @(posedge clk);
    i_write_n <= peri_fabric_pkg::ACC_NONE;
endtask

// Read held until ready, then kept for hold_cycles before read-complete
task automatic bus_read(input logic [`PERI_ADDR_W-1:0] addr, input int hold_cycles,
                        output logic [31:0] data, output int cycles);
    cycles = 0;
    @(posedge clk);
    i_addr   <= addr;
    i_read_n <= peri_fabric_pkg::ACC_WORD;
    @(negedge clk);
    while (!o_data_ready) begin
        cycles++;
        if (cycles > READ_TIMEOUT) begin
            abort_run($sformatf("Timeout waiting for read data from address 0x%03h", addr));
        end
        @(negedge clk);
    end
    data = o_rdata;
    repeat (hold_cycles) begin
        @(negedge clk);
        check_value("o_rdata", o_rdata, data);
        check_value("o_ext_read_n", 32'(o_ext_read_n), ALL_READ_NONE);
    end
    @(posedge clk);
    i_read_n        <= peri_fabric_pkg::ACC_NONE;
    i_read_complete <= 1'b1;
    @(posedge clk);
    i_read_complete <= 1'b0;
endtask

// Toggles one bit of a slot's pins and checks that the output pin follows
task automatic check_pin_follows(input int pin, input bit simple, input int idx);
    logic [7:0] pattern;
    for (int n = 0; n < 2; n++) begin
        pattern = (n == 0) ? 8'(1 << pin) : ~8'(1 << pin);
        @(posedge clk);
        if (simple) begin
            i_simple_pins[idx] <= pattern;
        end else begin
            i_ext_pins[idx] <= pattern;
        end
        @(negedge clk);
        check_value($sformatf("o_uo_out[%0d]", pin), 32'(o_uo_out[pin]), 32'(pattern[pin]));
    end
endtask

task automatic test_reset_defaults();
    logic [31:0] data;
    int          cycles;
    for (int p = 0; p < `PERI_PINS; p++) begin
        bus_read(gpio_addr(`PERI_GPIO_FUNC_OFS + 4 * p), 0, data, cycles);
        check_value($sformatf("pin_func[%0d]", p), data, (p < 2) ? 32'd2 : 32'd1);
    end
    check_pin_follows(0, 1'b0, 0);
    check_pin_follows(1, 1'b0, 0);
    check_value("o_uo_out[7:2]", 32'(o_uo_out[7:2]), 32'd0);
endtask

task automatic test_gpio();
    logic [31:0] data;
    int          cycles;
    logic [7:0]  value;
    logic [7:0]  ui;
    value = 8'($random(seed));
    bus_write(gpio_addr(`PERI_GPIO_OUT_OFS), {24'h0, value}, 8'h00, -1);
    bus_read(gpio_addr(`PERI_GPIO_OUT_OFS), 0, data, cycles);
    check_value("gpio_out", data, {24'h0, value});
    @(negedge clk);
    check_value("o_uo_out[7:2]", 32'(o_uo_out[7:2]), 32'(value[7:2]));
    ui = 8'($random(seed));
    @(posedge clk);
    i_ui_in <= ui;
    bus_read(gpio_addr(`PERI_GPIO_IN_OFS), 0, data, cycles);
    check_value("gpio_in", data, {24'h0, ui});
endtask

task automatic test_ext_read();
    logic [31:0] data;
    int          cycles;
    logic [5:0]  ofs;
    for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
        ofs = 6'(4 * k + 8);
        ext_expect = k;
        bus_write(11'((k + `PERI_EXT_FIRST) * 64 + ofs), $random(seed), 8'h00, k);
        bus_read(11'((k + `PERI_EXT_FIRST) * 64 + ofs), 3, data, cycles);
        check_value("o_rdata", data, ext_pattern(k + `PERI_EXT_FIRST, ofs));
        // Model ready follows its delay, o_data_ready comes one edge later
        check_value("read latency", cycles, ext_delay[k] + 2);
    end
    ext_expect = -1;
endtask

task automatic test_simple_slots();
    logic [31:0] data;
    int          cycles;
    logic [7:0]  value;
    logic [3:0]  ofs;
    for (int s = 0; s < `PERI_SIMPLE_SLOTS; s += 3) begin
        value = 8'($random(seed));
        ofs   = 4'(s + 5);
        bus_write(11'(SIMPLE_BASE + s * 16 + ofs), {24'hABCDEF, value}, 8'(1 << s), -1);
        bus_read(11'(SIMPLE_BASE + s * 16 + ofs), 0, data, cycles);
        check_value("o_rdata", data, {24'h0, value});
        check_value("read latency", cycles, 1);
    end
endtask

task automatic test_pin_routing();
    logic [31:0] data;
    int          cycles;
    // Pin 3 on simple slot 5
    bus_write(gpio_addr(`PERI_GPIO_FUNC_OFS + 4 * 3), 32'h0000_000D, 8'h00, -1);
    bus_read(gpio_addr(`PERI_GPIO_FUNC_OFS + 4 * 3), 0, data, cycles);
    check_value("pin_func[3]", data, 32'h0000_000D);
    check_pin_follows(3, 1'b1, 5);
    // Pin 6 on full slot 4
    bus_write(gpio_addr(`PERI_GPIO_FUNC_OFS + 4 * 6), 32'h0000_0004, 8'h00, -1);
    check_pin_follows(6, 1'b0, 4 - `PERI_EXT_FIRST);
endtask

task automatic test_unmapped_reads();
    logic [31:0]             data;
    int                      cycles;
    logic [`PERI_ADDR_W-1:0] addrs [4] = '{11'h010, 11'h200, 11'h2C8, 11'h480};
    // 0x2C8 has slot bits of full slot 3 but lies in the dropped upper region
    for (int i = 0; i < 4; i++) begin
        bus_read(addrs[i], 0, data, cycles);
        check_value("o_rdata", data, 32'd0);
        check_value("read latency", cycles, 1);
    end
endtask

`endif

// ==== testbench/tb_peri_fabric.sv ====
/*
 * Testbench top for the peripheral fabric.
 * Provides clock, reset, the DUT, models of the external and simple slots
 * and runs the directed tests from tb_peri_fabric_tasks.svh.
 */
`timescale 1ns/1ps
`default_nettype none

`include "peri_fabric_cfg.svh"

module tb_peri_fabric;

    localparam int READ_TIMEOUT = 50;
    localparam logic [`PERI_ADDR_W-1:0] GPIO_BASE   = 11'(`PERI_SLOT_GPIO * 64);
    localparam logic [`PERI_ADDR_W-1:0] SIMPLE_BASE = 11'h400;
    localparam logic [31:0] ALL_READ_NONE =
        {{(32 - 2 * `PERI_EXT_SLOTS){1'b0}}, {(2 * `PERI_EXT_SLOTS){1'b1}}};

    logic clk;
    logic rst_n = 1'b0;
    int   seed;
    int   error_count = 0;
    int   ext_expect = -1;

    logic [`PERI_ADDR_W-1:0]  i_addr = '0;
    logic [`PERI_DATA_W-1:0]  i_wdata = '0;
    peri_fabric_pkg::access_t i_write_n = peri_fabric_pkg::ACC_NONE;
    peri_fabric_pkg::access_t i_read_n = peri_fabric_pkg::ACC_NONE;
    logic                     i_read_complete = 1'b0;
    logic [`PERI_DATA_W-1:0]  o_rdata;
    logic                     o_data_ready;

    logic [`PERI_FULL_OFS_W-1:0]                         o_ext_addr;
    logic [`PERI_DATA_W-1:0]                             o_ext_wdata;
    peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]      o_ext_write_n;
    peri_fabric_pkg::access_t [`PERI_EXT_SLOTS-1:0]      o_ext_read_n;
    logic [`PERI_EXT_SLOTS-1:0][`PERI_DATA_W-1:0]        i_ext_rdata = '0;
    logic [`PERI_EXT_SLOTS-1:0]                          i_ext_ready = '0;
    logic [`PERI_EXT_SLOTS-1:0][`PERI_PINS-1:0]          i_ext_pins = '0;

    logic [`PERI_SIMPLE_OFS_W-1:0]                       o_simple_addr;
    logic [7:0]                                          o_simple_wdata;
    logic [`PERI_SIMPLE_SLOTS-1:0]                       o_simple_write;
    wire  [`PERI_SIMPLE_SLOTS-1:0][7:0]                  i_simple_rdata;
    logic [`PERI_SIMPLE_SLOTS-1:0][`PERI_PINS-1:0]       i_simple_pins = '0;

    logic [`PERI_PINS-1:0] i_ui_in = '0;
    logic [`PERI_PINS-1:0] o_uo_out;

    // External slot model state
    int         ext_wait [`PERI_EXT_SLOTS];
    int         ext_delay [`PERI_EXT_SLOTS];
    logic [7:0] simple_mem [`PERI_SIMPLE_SLOTS][16];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    peri_fabric_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_wdata         (i_wdata),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready),
        .o_ext_addr      (o_ext_addr),
        .o_ext_wdata     (o_ext_wdata),
        .o_ext_write_n   (o_ext_write_n),
        .o_ext_read_n    (o_ext_read_n),
        .i_ext_rdata     (i_ext_rdata),
        .i_ext_ready     (i_ext_ready),
        .i_ext_pins      (i_ext_pins),
        .o_simple_addr   (o_simple_addr),
        .o_simple_wdata  (o_simple_wdata),
        .o_simple_write  (o_simple_write),
        .i_simple_rdata  (i_simple_rdata),
        .i_simple_pins   (i_simple_pins),
        .i_ui_in         (i_ui_in),
        .o_uo_out        (o_uo_out)
    );

    // Read data of an external slot, built from slot number and offset
    function automatic logic [31:0] ext_pattern(input int slot, input logic [5:0] ofs);
        return {8'hC0 | 8'(slot), 2'b00, ofs, 2'b11, ~ofs, 8'h5A};
    endfunction

    // External slots answer a read after their own delay
    always @(posedge clk) begin
        for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
            if (!rst_n || o_ext_read_n[k] == peri_fabric_pkg::ACC_NONE) begin
                ext_wait[k]    <= 0;
                i_ext_ready[k] <= 1'b0;
                i_ext_rdata[k] <= 32'hDEAD_0000 | 32'(k);
            end else if (ext_wait[k] >= ext_delay[k]) begin
                i_ext_ready[k] <= 1'b1;
                i_ext_rdata[k] <= ext_pattern(k + `PERI_EXT_FIRST, o_ext_addr);
            end else begin
                ext_wait[k] <= ext_wait[k] + 1;
            end
        end
    end

    // Simple slots store one byte per offset
    always @(posedge clk) begin
        for (int s = 0; s < `PERI_SIMPLE_SLOTS; s++) begin
            if (o_simple_write[s]) begin
                simple_mem[s][o_simple_addr] <= o_simple_wdata;
            end
        end
    end

    for (genvar s = 0; s < `PERI_SIMPLE_SLOTS; s++) begin : g_simple_model
        assign i_simple_rdata[s] = simple_mem[s][o_simple_addr];
    end

    // Only the slot under test may ever see a read code
    always @(negedge clk) begin
        if (rst_n) begin
            for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
                if (k != ext_expect && o_ext_read_n[k] != peri_fabric_pkg::ACC_NONE) begin
                    abort_run($sformatf("Read code seen on unselected external slot %0d", k));
                end
            end
        end
    end

    task automatic abort_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    `include "tb_peri_fabric_tasks.svh"

    initial begin
        seed = 96;
        for (int s = 0; s < `PERI_SIMPLE_SLOTS; s++) begin
            for (int o = 0; o < 16; o++) begin
                simple_mem[s][o] = 8'(s * 16 + o) ^ 8'h5A;
            end
        end
        for (int k = 0; k < `PERI_EXT_SLOTS; k++) begin
            ext_delay[k] = 2 * k + ($unsigned($random(seed)) % 2);
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_defaults();
        test_gpio();
        test_ext_read();
        test_simple_slots();
        test_pin_routing();
        test_unmapped_reads();

        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== peri_fabric.f ====
+incdir+source
+incdir+testbench
source/peri_fabric_pkg.sv
source/peri_bus_decoder.sv
source/peri_gpio_regs.sv
source/peri_read_buffer.sv
source/peri_pin_mux.sv
source/peri_fabric_top.sv
testbench/tb_peri_fabric.sv

// ==== Bender.yml ====
package:
  name: peri_fabric

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/peri_fabric_pkg.sv
      - source/peri_bus_decoder.sv
      - source/peri_gpio_regs.sv
      - source/peri_read_buffer.sv
      - source/peri_pin_mux.sv
      - source/peri_fabric_top.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_peri_fabric.sv
